// File: source/sa_pkg.sv
package sa_pkg;

    // ******************************
    // Array geometry and widths.
    // ******************************
    localparam int ARRAY_SIZE     = 4;
    localparam int DATA_WIDTH     = 8;
    localparam int ACC_WIDTH      = 20;  // Four 16-bit products fit.

    localparam int IN_FIFO_DEPTH  = 16;
    localparam int OUT_FIFO_DEPTH = 8;

    // ******************************
    // Payload types.
    // ******************************
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ACC_WIDTH-1:0]  acc_t;

    // Lane 0 / column 0 sits in the lowest bits.
    typedef data_t [ARRAY_SIZE-1:0] data_vec_t;
    typedef acc_t  [ARRAY_SIZE-1:0] acc_vec_t;

    // Row select for weight loading.
    typedef logic [$clog2(ARRAY_SIZE)-1:0] row_idx_t;

endpackage

// File: source/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     wr_i,
    input  payload_t wr_data_i,
    input  logic     rd_i,
    output logic     rd_valid_o,
    output payload_t rd_data_o,
    output logic     full_o,
    output logic     empty_o
);

    payload_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    assign full_o  = (count == DEPTH);
    assign empty_o = (count == 0);

    // Pointers, occupancy and read valid.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_i;
            if (wr_i) begin
                wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_i, rd_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read data.
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (rd_i) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
        wr_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
        rd_i |-> !empty_o);

endmodule

// File: source/skew_buffer.sv
module skew_buffer import sa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  wr_i,
    input  data_vec_t             wr_data_i,
    output logic                  full_o,
    output logic [ARRAY_SIZE-1:0] lane_valid_o,
    output data_vec_t             lane_data_o
);

    logic [ARRAY_SIZE-1:0] lane_rd;
    logic [ARRAY_SIZE-1:1] rd_sr;
    logic [ARRAY_SIZE-1:0] lane_full;
    logic [ARRAY_SIZE-1:0] lane_empty;

    // ******************************
    // Staggered read strobes.
    // ******************************
    assign lane_rd = {rd_sr, !lane_empty[0]};  // Drain lane 0 as soon as it holds data.

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_sr <= '0;
        end else begin
            rd_sr <= lane_rd[ARRAY_SIZE-2:0];
        end
    end

    // ******************************
    // Per-lane activation FIFOs.
    // ******************************
    for (genvar k = 0; k < ARRAY_SIZE; k++) begin : g_lane
        sync_fifo #(
            .payload_t (data_t),
            .DEPTH     (IN_FIFO_DEPTH)
        ) u_fifo (
            .clk        (clk),
            .reset_i    (reset_i),
            .wr_i       (wr_i),
            .wr_data_i  (wr_data_i[k]),
            .rd_i       (lane_rd[k]),
            .rd_valid_o (lane_valid_o[k]),
            .rd_data_o  (lane_data_o[k]),
            .full_o     (lane_full[k]),
            .empty_o    (lane_empty[k])
        );
    end

    assign full_o = lane_full[ARRAY_SIZE-1];  // Last lane drains last.

endmodule

// File: source/mac_pe.sv
module mac_pe import sa_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  w_load_i,
    input  data_t w_i,
    input  logic  a_valid_i,
    input  data_t a_i,
    input  acc_t  sum_i,
    output logic  a_valid_o,
    output data_t a_o,
    output acc_t  sum_o
);

    data_t                   weight;
    logic [2*DATA_WIDTH-1:0] prod;

    assign prod = weight * a_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            a_valid_o <= 1'b0;
        end else begin
            a_valid_o <= a_valid_i;
        end
    end

    // Stationary weight, activation forwarding and accumulation.
    always_ff @(posedge clk) begin
        if (w_load_i) begin
            weight <= w_i;
        end
        if (a_valid_i) begin
            a_o   <= a_i;
            sum_o <= sum_i + acc_t'(prod);
        end
    end

endmodule

// File: source/pe_array.sv
module pe_array import sa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  w_load_i,
    input  row_idx_t              w_row_i,
    input  data_vec_t             w_data_i,
    input  logic [ARRAY_SIZE-1:0] lane_valid_i,
    input  data_vec_t             lane_data_i,
    output logic [ARRAY_SIZE-1:0] col_valid_o,
    output acc_vec_t              col_sum_o
);

    logic [ARRAY_SIZE-1:0] row_load;

    // Horizontal activation path with one extra tap at the right edge of each row.
    logic [ARRAY_SIZE-1:0][ARRAY_SIZE:0] a_v;
    data_t a_d [ARRAY_SIZE][ARRAY_SIZE+1];

    // Vertical partial-sum path. Row 0 is the zero input at the top.
    acc_t psum [ARRAY_SIZE+1][ARRAY_SIZE];

    for (genvar i = 0; i < ARRAY_SIZE; i++) begin : g_row
        assign row_load[i] = w_load_i && (w_row_i == row_idx_t'(i));
        assign a_v[i][0]   = lane_valid_i[i];
        assign a_d[i][0]   = lane_data_i[i];
        assign psum[0][i]  = '0;

        for (genvar j = 0; j < ARRAY_SIZE; j++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .reset_i   (reset_i),
                .w_load_i  (row_load[i]),
                .w_i       (w_data_i[j]),
                .a_valid_i (a_v[i][j]),
                .a_i       (a_d[i][j]),
                .sum_i     (psum[i][j]),
                .a_valid_o (a_v[i][j+1]),
                .a_o       (a_d[i][j+1]),
                .sum_o     (psum[i+1][j])
            );
        end
    end

    // Bottom row results.
    for (genvar j = 0; j < ARRAY_SIZE; j++) begin : g_out
        assign col_valid_o[j] = a_v[ARRAY_SIZE-1][j+1];
        assign col_sum_o[j]   = psum[ARRAY_SIZE][j];
    end

    // Weights change only with nothing entering or moving through the grid.
    a_load_idle: assert property (@(posedge clk) disable iff (reset_i)
        w_load_i |-> !(|lane_valid_i) && !(|a_v));

endmodule

// File: source/deskew_unit.sv
module deskew_unit import sa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [ARRAY_SIZE-1:0] col_valid_i,
    input  acc_vec_t              col_sum_i,
    input  logic                  rd_i,
    output logic                  rd_valid_o,
    output acc_vec_t              rd_data_o,
    output logic                  empty_o
);

    logic [ARRAY_SIZE-1:0] al_valid;
    acc_vec_t              al_sum;

    // ******************************
    // Column delay lines.
    // ******************************
    for (genvar j = 0; j < ARRAY_SIZE; j++) begin : g_col
        if (j == ARRAY_SIZE-1) begin : g_pass
            assign al_valid[j] = col_valid_i[j];  // Latest column needs no delay.
            assign al_sum[j]   = col_sum_i[j];
        end else begin : g_dly
            logic [ARRAY_SIZE-2-j:0] v_sr;
            acc_t                    s_sr [ARRAY_SIZE-1-j];

            always_ff @(posedge clk) begin
                if (reset_i) begin
                    v_sr <= '0;
                end else begin
                    v_sr[0] <= col_valid_i[j];
                    for (int d = 1; d < ARRAY_SIZE-1-j; d++) begin
                        v_sr[d] <= v_sr[d-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                s_sr[0] <= col_sum_i[j];
                for (int d = 1; d < ARRAY_SIZE-1-j; d++) begin
                    s_sr[d] <= s_sr[d-1];
                end
            end

            assign al_valid[j] = v_sr[ARRAY_SIZE-2-j];
            assign al_sum[j]   = s_sr[ARRAY_SIZE-2-j];
        end
    end

    // ******************************
    // Result queue.
    // ******************************
    sync_fifo #(
        .payload_t (acc_vec_t),
        .DEPTH     (OUT_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_i       (al_valid[0]),
        .wr_data_i  (al_sum),
        .rd_i       (rd_i),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .full_o     (),
        .empty_o    (empty_o)
    );

    // Every column of a vector lines up in the same cycle.
    a_cols_aligned: assert property (@(posedge clk) disable iff (reset_i)
        (al_valid == '0) || (al_valid == '1));

endmodule

// File: source/systolic_top.sv
module systolic_top import sa_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      in_valid_i,
    input  data_vec_t in_data_i,
    output logic      in_full_o,
    input  logic      w_load_i,
    input  row_idx_t  w_row_i,
    input  data_vec_t w_data_i,
    input  logic      out_rd_i,
    output logic      out_valid_o,
    output acc_vec_t  out_data_o,
    output logic      out_empty_o
);

    logic [ARRAY_SIZE-1:0] lane_valid;
    data_vec_t             lane_data;
    logic [ARRAY_SIZE-1:0] col_valid;
    acc_vec_t              col_sum;

    // Input side.
    skew_buffer u_skew (
        .clk          (clk),
        .reset_i      (reset_i),
        .wr_i         (in_valid_i),
        .wr_data_i    (in_data_i),
        .full_o       (in_full_o),
        .lane_valid_o (lane_valid),
        .lane_data_o  (lane_data)
    );

    pe_array u_array (
        .clk          (clk),
        .reset_i      (reset_i),
        .w_load_i     (w_load_i),
        .w_row_i      (w_row_i),
        .w_data_i     (w_data_i),
        .lane_valid_i (lane_valid),
        .lane_data_i  (lane_data),
        .col_valid_o  (col_valid),
        .col_sum_o    (col_sum)
    );

    // Output side.
    deskew_unit u_deskew (
        .clk         (clk),
        .reset_i     (reset_i),
        .col_valid_i (col_valid),
        .col_sum_i   (col_sum),
        .rd_i        (out_rd_i),
        .rd_valid_o  (out_valid_o),
        .rd_data_o   (out_data_o),
        .empty_o     (out_empty_o)
    );

endmodule

// File: dv/tb_systolic.sv
module tb_systolic import sa_pkg::*; ();

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int IDENT_VECTORS  = 6;
    localparam int STREAM_VECTORS = 40;
    localparam int HELD_VECTORS   = 6;
    localparam int RELOAD_VECTORS = 20;
    localparam int MAX_VECTORS    = 8;
    localparam int NUM_VECTORS    = IDENT_VECTORS + STREAM_VECTORS + HELD_VECTORS
                                  + RELOAD_VECTORS + MAX_VECTORS;
    localparam int MARGIN         = 50;  // Cycles allowed per vector.
    localparam int TIMEOUT        = (RESET_CYCLES + NUM_VECTORS * MARGIN) * CLK_PERIOD;
    localparam int MAX_RESULT     = ARRAY_SIZE * 255 * 255;

    logic      clk;
    logic      reset_i;
    logic      in_valid_i;
    data_vec_t in_data_i;
    logic      in_full_o;
    logic      w_load_i;
    row_idx_t  w_row_i;
    data_vec_t w_data_i;
    logic      out_rd_i;
    logic      out_valid_o;
    acc_vec_t  out_data_o;
    logic      out_empty_o;

    data_t    weights [ARRAY_SIZE][ARRAY_SIZE];  // Golden copy of W[row][col].
    acc_vec_t exp_mem [128];                     // Expected results in write order.
    int       wr_idx = 0;
    int       rd_idx = 0;
    int       sent = 0;
    int       seed = 76;

    systolic_top uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_full_o   (in_full_o),
        .w_load_i    (w_load_i),
        .w_row_i     (w_row_i),
        .w_data_i    (w_data_i),
        .out_rd_i    (out_rd_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_empty_o (out_empty_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before all results came back.");
        $display("Test failed");
        $fatal(1);
    end

    task automatic report_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (out_valid_o) begin
            rd_idx <= rd_idx + 1;  // Queue head moves on each result.
        end
    end

    // ******************************
    // Checks.
    // ******************************
    a_reset_state: assert property (@(posedge clk)
        reset_i |=> out_empty_o && !out_valid_o && !in_full_o)
        else report_error("outputs not idle during or after reset");

    a_no_write_full: assert property (@(posedge clk) disable iff (reset_i)
        in_valid_i |-> !in_full_o) else report_error("write while input full");

    a_read_answered: assert property (@(posedge clk) disable iff (reset_i)
        out_rd_i |=> out_valid_o) else report_error("read strobe got no valid result");

    a_valid_requested: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o |-> $past(out_rd_i)) else report_error("result valid without a read");

    a_result_match: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o |-> out_data_o == exp_mem[rd_idx])
        else report_error($sformatf("result %0d is %h, model gives %h", $sampled(rd_idx),
                                    $sampled(out_data_o), $sampled(exp_mem[rd_idx])));

    // ******************************
    // Golden model and stimulus.
    // ******************************
    function automatic acc_vec_t model_result(input data_vec_t a);
        acc_vec_t y;
        int       sum;
        for (int j = 0; j < ARRAY_SIZE; j++) begin
            sum = 0;
            for (int i = 0; i < ARRAY_SIZE; i++) begin
                sum += int'(a[i]) * int'(weights[i][j]);
            end
            y[j] = acc_t'(sum);
        end
        return y;
    endfunction

    function automatic data_vec_t random_vector();
        data_vec_t v;
        for (int k = 0; k < ARRAY_SIZE; k++) begin
            v[k] = data_t'($random(seed));
        end
        return v;
    endfunction

    task automatic pick_random_weights();
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                weights[i][j] = data_t'($random(seed));
            end
        end
    endtask

    task automatic load_weights();
        data_vec_t row;
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                row[j] = weights[i][j];
            end
            @(posedge clk);
            w_load_i <= 1'b1;
            w_row_i  <= row_idx_t'(i);
            w_data_i <= row;
        end
        @(posedge clk);
        w_load_i <= 1'b0;
    endtask

    task automatic send_vector(input data_vec_t v, input acc_vec_t y);
        @(posedge clk);
        in_valid_i      <= 1'b1;
        in_data_i       <= v;
        exp_mem[wr_idx] <= y;
        wr_idx          <= wr_idx + 1;
        sent++;
    endtask

    task automatic end_writes();
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    task automatic send_random_burst(input int count);
        data_vec_t v;
        repeat (count) begin
            v = random_vector();
            send_vector(v, model_result(v));
        end
        end_writes();
    endtask

    // Pops one result per cycle while the queue holds data.
    task automatic collect_results(input int count);
        int issued;
        issued = 0;
        while (issued < count) begin
            @(posedge clk);
            if (!out_empty_o) begin
                out_rd_i <= 1'b1;
                issued++;
            end else begin
                out_rd_i <= 1'b0;
            end
        end
        @(posedge clk);
        out_rd_i <= 1'b0;
    endtask

    task automatic pop_one();
        while (out_empty_o) @(posedge clk);
        out_rd_i <= 1'b1;
        @(posedge clk);
        out_rd_i <= 1'b0;
        while (!out_valid_o) @(posedge clk);
    endtask

    task automatic wait_drained();
        while (rd_idx != sent) @(posedge clk);
        repeat (2 * ARRAY_SIZE + 2) @(posedge clk);  // Room for a stray result.
        a_all_returned: assert (out_empty_o && rd_idx == sent)
            else report_error($sformatf("%0d results for %0d vectors", rd_idx, sent));
    endtask

    initial begin
        data_vec_t v;
        acc_vec_t  y;
        reset_i    = 1'b1;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        w_load_i   = 1'b0;
        w_row_i    = '0;
        w_data_i   = '0;
        out_rd_i   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                weights[i][j] = (i == j) ? 8'd1 : 8'd0;
            end
        end
        load_weights();
        repeat (IDENT_VECTORS) begin
            v = random_vector();
            for (int k = 0; k < ARRAY_SIZE; k++) begin
                y[k] = acc_t'(v[k]);
            end
            send_vector(v, y);
            end_writes();
            collect_results(1);
            wait_drained();
        end

        pick_random_weights();
        load_weights();
        fork
            send_random_burst(STREAM_VECTORS);
            collect_results(STREAM_VECTORS);
        join
        wait_drained();

        send_random_burst(HELD_VECTORS);  // Held until the queue has data.
        do begin
            @(posedge clk);
        end while (out_empty_o);
        repeat (HELD_VECTORS) begin
            pop_one();
            repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk);
        end
        wait_drained();

        pick_random_weights();
        load_weights();
        fork
            send_random_burst(RELOAD_VECTORS);
            collect_results(RELOAD_VECTORS);
        join
        wait_drained();

        // ******************************
        // Largest operands.
        // ******************************
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                weights[i][j] = 8'hFF;
            end
            y[i] = acc_t'(MAX_RESULT);
        end
        load_weights();
        fork
            begin
                repeat (MAX_VECTORS) send_vector('1, y);
                end_writes();
            end
            collect_results(MAX_VECTORS);
        join
        wait_drained();

        $display("Test passed");
        $finish;
    end

endmodule

// File: sources.f
source/sa_pkg.sv
source/sync_fifo.sv
source/skew_buffer.sv
source/mac_pe.sv
source/pe_array.sv
source/deskew_unit.sv
source/systolic_top.sv
dv/tb_systolic.sv

// File: Bender.yml
package:
  name: systolic_array

sources:
  - source/sa_pkg.sv
  - source/sync_fifo.sv
  - source/skew_buffer.sv
  - source/mac_pe.sv
  - source/pe_array.sv
  - source/deskew_unit.sv
  - source/systolic_top.sv
  - target: simulation
    files:
      - dv/tb_systolic.sv
